//--- hw/sxp_settings.svh
`ifndef SXP_SETTINGS_SVH
`define SXP_SETTINGS_SVH

// core widths
`define SXP_DATA_W  32   // data, pc and instruction width
`define SXP_RF_W    4    // register address width
`define SXP_RF_SIZE 16   // number of registers
`define SXP_IMM_W   16   // immediate width, zero extended

// instruction field positions
`define SXP_F_DEST_CFG 31:30  // destination config
`define SXP_F_SRC_CFG  29:27  // operand source config
`define SXP_F_ALU_OP   26:24  // alu operation
`define SXP_F_WB_CFG   23:20  // write-back source
`define SXP_F_DEST     19:16  // destination register
`define SXP_F_RA       15:12  // register a
`define SXP_F_RB       11:8   // register b
`define SXP_F_IMM      15:0   // immediate, overlaps ra/rb
`define SXP_F_COND     0      // conditional jump
`define SXP_F_JZ       1      // jump on zero, else on non-zero

`endif

//--- hw/sxp_pkg.sv
`default_nettype none

`include "sxp_settings.svh"

package sxp_pkg;

  typedef logic [`SXP_DATA_W-1:0] data_t;     // data word
  typedef logic [`SXP_DATA_W-1:0] inst_t;     // instruction word
  typedef logic [`SXP_RF_W-1:0]   rf_addr_t;  // register number
  typedef logic [`SXP_IMM_W-1:0]  imm_t;      // raw immediate
  typedef logic [3:0]             cvnz_t;     // {c, v, n, z}

  // where the result goes
  typedef enum logic [1:0] {
    DEST_REG   = 2'b00,
    DEST_JUMP  = 2'b01,
    DEST_STORE = 2'b10,
    DEST_NONE  = 2'b11   // reserved, no-op
  } dest_cfg_e;

  // operand sources, 1xx reserved
  typedef enum logic [2:0] {
    SRC_RR = 3'b000,  // a reg, b reg
    SRC_RI = 3'b001,  // a from dest field reg, b imm
    SRC_PR = 3'b010,  // a pcn, b reg
    SRC_PI = 3'b011   // a pcn, b imm
  } src_cfg_e;

  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SHL, ALU_SHR, ALU_PASSB
  } alu_op_e;

  // write-back source, flags are zero extended
  typedef enum logic [3:0] {
    WB_RESULT = 4'b0000,
    WB_Z      = 4'b0100,
    WB_N      = 4'b0101,
    WB_V      = 4'b0110,
    WB_C      = 4'b0111
  } wb_cfg_e;

endpackage

`default_nettype wire

//--- hw/sxp_alu.sv
`default_nettype none

`include "sxp_settings.svh"

module sxp_alu
(
  input  wire sxp_pkg::alu_op_e op,
  input  wire sxp_pkg::data_t   a,
  input  wire sxp_pkg::data_t   b,
  output sxp_pkg::data_t        y,
  output sxp_pkg::cvnz_t        cvnz   // {c, v, n, z}
);

  import sxp_pkg::*;

  localparam int MSB = `SXP_DATA_W - 1;

  logic [`SXP_DATA_W:0] sum;   // extra bit is carry
  logic [`SXP_DATA_W:0] diff;  // extra bit is borrow
  logic v_add;
  logic v_sub;
  logic c;
  logic v;

  assign sum   = {1'b0, a} + {1'b0, b};
  assign diff  = {1'b0, a} - {1'b0, b};
  assign v_add = (a[MSB] == b[MSB]) & (sum[MSB] != a[MSB]);  // like signs, sign flips
  assign v_sub = (a[MSB] != b[MSB]) & (diff[MSB] != a[MSB]);

  always_comb
  begin
    c = 1'b0;
    v = 1'b0;
    case (op)
      ALU_ADD:
      begin
        y = sum[MSB:0];
        c = sum[`SXP_DATA_W];
        v = v_add;
      end
      ALU_SUB:
      begin
        y = diff[MSB:0];
        c = ~diff[`SXP_DATA_W];  // not borrow
        v = v_sub;
      end
      ALU_AND: y = a & b;
      ALU_OR:  y = a | b;
      ALU_XOR: y = a ^ b;
      ALU_SHL: y = a << b[4:0];
      ALU_SHR: y = a >> b[4:0];  // logical
      default: y = b;            // passb
    endcase
  end

  assign cvnz = {c, v, y[MSB], (y == '0)};

endmodule

`default_nettype wire

//--- hw/sxp_regf.sv
`default_nettype none

`include "sxp_settings.svh"

module sxp_regf
(
  input  wire                  clk,
  input  wire                  reset_b,
  input  wire sxp_pkg::rf_addr_t addra,
  input  wire sxp_pkg::rf_addr_t addrb,
  input  wire sxp_pkg::rf_addr_t addrc,  // write port
  input  wire                  a_en,
  input  wire                  b_en,
  input  wire                  wec,
  input  wire sxp_pkg::data_t  dc,
  output sxp_pkg::data_t       qra,      // registered read a
  output sxp_pkg::data_t       qrb       // registered read b
);

  import sxp_pkg::*;

  data_t regs [`SXP_RF_SIZE];

  always_ff @(posedge clk or negedge reset_b)
  begin
    if (!reset_b)
    begin
      for (int i = 0; i < `SXP_RF_SIZE; i++)
        regs[i] <= '0;
    end
    else if (wec)
      regs[addrc] <= dc;
  end

  // reads see a write on the same edge
  always_ff @(posedge clk or negedge reset_b)
  begin
    if (!reset_b)
    begin
      qra <= '0;
      qrb <= '0;
    end
    else
    begin
      if (a_en)
        qra <= (wec && addrc == addra) ? dc : regs[addra];
      if (b_en)
        qrb <= (wec && addrc == addrb) ? dc : regs[addrb];
    end
  end

endmodule

`default_nettype wire

//--- hw/sxp_regf_status.sv
`default_nettype none

`include "sxp_settings.svh"

module sxp_regf_status
(
  input  wire                    clk,
  input  wire                    reset_b,
  input  wire                    dest_en,         // stage-1 inst writes a reg
  input  wire sxp_pkg::rf_addr_t dest_addr,
  input  wire sxp_pkg::rf_addr_t addra,
  input  wire sxp_pkg::rf_addr_t addrb,
  input  wire sxp_pkg::rf_addr_t addrc,           // write-back address
  input  wire                    a_en,
  input  wire                    b_en,
  input  wire                    wec,             // write-back strobe
  input  wire                    flush_pipeline,  // drops all in-flight writes
  output logic                   stall            // hold fetch and stage 1
);

  logic [`SXP_RF_SIZE-1:0] pending;  // write outstanding per reg
  logic [`SXP_RF_SIZE-1:0] clr_mask;
  logic [`SXP_RF_SIZE-1:0] set_mask;
  logic [`SXP_RF_SIZE-1:0] busy;     // pending after this cycle's write-back

  assign clr_mask = {{(`SXP_RF_SIZE-1){1'b0}}, wec} << addrc;
  assign busy     = pending & ~clr_mask;  // regf bypass makes the write visible now

  // waw also stalls so a bit has a single owner
  assign stall = (a_en & busy[addra]) |
                 (b_en & busy[addrb]) |
                 (dest_en & busy[dest_addr]);

  assign set_mask = {{(`SXP_RF_SIZE-1){1'b0}}, dest_en & ~stall} << dest_addr;

  always_ff @(posedge clk or negedge reset_b)
  begin
    if (!reset_b)
      pending <= '0;
    else if (flush_pipeline)
      pending <= '0;                  // younger insts are discarded
    else
      pending <= busy | set_mask;     // set wins over clear
  end

endmodule

`default_nettype wire

//--- hw/sxp_fetch.sv
`default_nettype none

`include "sxp_settings.svh"

module sxp_fetch
(
  input  wire                      clk,
  input  wire                      reset_b,
  input  wire                      stall,      // hold pc and current inst
  input  wire                      set_pc,     // redirect from write-back
  input  wire sxp_pkg::data_t      pc_init,    // jump target
  input  wire sxp_pkg::inst_t      mem_inst,   // returned one clock after mem_pc
  output sxp_pkg::data_t           mem_pc,
  output sxp_pkg::data_t           pcn,        // address after the stage-1 inst
  output logic                     inst_vld,
  output sxp_pkg::dest_cfg_e       dest_cfg,
  output sxp_pkg::src_cfg_e        src_cfg,
  output sxp_pkg::alu_op_e         alu_op,
  output sxp_pkg::wb_cfg_e         wb_cfg,
  output sxp_pkg::rf_addr_t        dest_addr,
  output sxp_pkg::rf_addr_t        addra,
  output sxp_pkg::rf_addr_t        addrb,
  output sxp_pkg::imm_t            imm,
  output logic                     cond_jump,
  output logic                     jz,
  output logic                     a_en,       // reg a read and scoreboard check
  output logic                     b_en,
  output logic                     dest_en     // reg destination, scoreboard set
);

  import sxp_pkg::*;

  data_t pc;        // address presented to memory
  inst_t inst;      // stage-1 instruction
  inst_t inst_r;    // copy kept while stalled
  logic  held;      // memory output is stale, use inst_r
  logic  redir_1;   // first cycle after a redirect
  logic  redir_2;   // second cycle, memory returns the target

  // reset looks like a redirect to address 0
  always_ff @(posedge clk or negedge reset_b)
  begin
    if (!reset_b)
    begin
      pc      <= '0;
      held    <= 1'b0;
      redir_1 <= 1'b1;
      redir_2 <= 1'b1;
    end
    else
    begin
      redir_1 <= set_pc;
      redir_2 <= redir_1;
      held    <= stall & ~set_pc;
      if (set_pc)
        pc <= pc_init;
      else if (!stall && !redir_1)  // target is presented twice
        pc <= pc + data_t'(1);
    end
  end

  always_ff @(posedge clk)
  begin
    if (stall)
      inst_r <= inst;
  end

  assign inst     = held ? inst_r : mem_inst;
  assign inst_vld = ~redir_1 & ~redir_2;
  assign mem_pc   = pc;
  assign pcn      = pc;  // pc is one ahead of the stage-1 inst

  // field decode
  assign dest_cfg  = dest_cfg_e'(inst[`SXP_F_DEST_CFG]);
  assign src_cfg   = src_cfg_e'(inst[`SXP_F_SRC_CFG]);
  assign alu_op    = alu_op_e'(inst[`SXP_F_ALU_OP]);
  assign wb_cfg    = wb_cfg_e'(inst[`SXP_F_WB_CFG]);
  assign dest_addr = inst[`SXP_F_DEST];
  assign addra     = (src_cfg == SRC_RI) ? dest_addr : inst[`SXP_F_RA];
  assign addrb     = inst[`SXP_F_RB];
  assign imm       = inst[`SXP_F_IMM];
  assign jz        = inst[`SXP_F_JZ];
  assign cond_jump = inst[`SXP_F_COND] & b_en;  // needs a register b to test

  always_comb
  begin
    a_en = 1'b0;
    b_en = 1'b0;
    if (inst_vld)
    begin
      case (src_cfg)
        SRC_RR:  {a_en, b_en} = 2'b11;
        SRC_RI:  a_en = 1'b1;
        SRC_PR:  b_en = 1'b1;
        default: {a_en, b_en} = 2'b00;  // pc/imm only or reserved
      endcase
    end
  end

  // reserved sources never write, so they must not set a pending bit
  assign dest_en = inst_vld & (dest_cfg == DEST_REG) & ~src_cfg[2];

endmodule

`default_nettype wire

//--- hw/sxp_execute.sv
`default_nettype none

module sxp_execute
(
  input  wire                     clk,
  input  wire                     reset_b,
  input  wire                     stall,       // bubble into stage 2
  input  wire                     inst_vld,
  input  wire sxp_pkg::dest_cfg_e dest_cfg,
  input  wire sxp_pkg::src_cfg_e  src_cfg,
  input  wire sxp_pkg::alu_op_e   alu_op,
  input  wire sxp_pkg::wb_cfg_e   wb_cfg,
  input  wire sxp_pkg::rf_addr_t  dest_addr,
  input  wire sxp_pkg::imm_t      imm,
  input  wire sxp_pkg::data_t     pcn,
  input  wire                     cond_jump,
  input  wire                     jz,
  input  wire sxp_pkg::data_t     qra,         // regf reads, valid in stage 2
  input  wire sxp_pkg::data_t     qrb,
  input  wire sxp_pkg::data_t     y,           // alu result from stage 3
  input  wire sxp_pkg::cvnz_t     cvnz,
  output sxp_pkg::alu_op_e        alu_op_3,
  output sxp_pkg::data_t          a_3,
  output sxp_pkg::data_t          b_3,
  output logic                    wec,
  output sxp_pkg::rf_addr_t       addrc,
  output sxp_pkg::data_t          wb_data,
  output logic                    set_pc,
  output logic                    flush_pipeline,
  output logic                    spw_we,
  output sxp_pkg::data_t          spw_addr,
  output sxp_pkg::data_t          spw_data
);

  import sxp_pkg::*;

  // stage 2
  logic      vld_2;
  dest_cfg_e dest_cfg_2;
  src_cfg_e  src_cfg_2;
  alu_op_e   alu_op_2;
  wb_cfg_e   wb_cfg_2;
  rf_addr_t  dest_addr_2;
  imm_t      imm_2;
  data_t     pcn_2;
  logic      cond_jump_2;
  logic      jz_2;
  data_t     a_2;
  data_t     b_2;
  // stage 3
  logic      vld_3;
  dest_cfg_e dest_cfg_3;
  wb_cfg_e   wb_cfg_3;
  rf_addr_t  dest_addr_3;
  data_t     pcn_3;
  logic      cond_jump_3;
  logic      jz_3;
  // stage 4
  logic      vld_4;
  dest_cfg_e dest_cfg_4;
  wb_cfg_e   wb_cfg_4;
  data_t     pcn_4;
  logic      cond_jump_4;
  logic      jz_4;
  data_t     y_4;
  data_t     b_4;
  cvnz_t     cvnz_4;
  logic      take;      // jump condition met

  always_ff @(posedge clk or negedge reset_b)
  begin
    if (!reset_b)
    begin
      vld_2 <= 1'b0;
      vld_3 <= 1'b0;
      vld_4 <= 1'b0;
    end
    else if (flush_pipeline)
    begin
      vld_2 <= 1'b0;
      vld_3 <= 1'b0;
      vld_4 <= 1'b0;
    end
    else
    begin
      vld_2 <= inst_vld & ~stall;
      vld_3 <= vld_2 & ~src_cfg_2[2];  // reserved sources die here
      vld_4 <= vld_3;
    end
  end

  always_ff @(posedge clk)
  begin
    if (inst_vld && !stall)
    begin
      dest_cfg_2  <= dest_cfg;
      src_cfg_2   <= src_cfg;
      alu_op_2    <= alu_op;
      wb_cfg_2    <= wb_cfg;
      dest_addr_2 <= dest_addr;
      imm_2       <= imm;
      pcn_2       <= pcn;
      cond_jump_2 <= cond_jump;
      jz_2        <= jz;
    end
    if (vld_2)
    begin
      a_3         <= a_2;
      b_3         <= b_2;
      alu_op_3    <= alu_op_2;
      dest_cfg_3  <= dest_cfg_2;
      wb_cfg_3    <= wb_cfg_2;
      dest_addr_3 <= dest_addr_2;
      pcn_3       <= pcn_2;
      cond_jump_3 <= cond_jump_2;
      jz_3        <= jz_2;
    end
    if (vld_3)
    begin
      y_4         <= y;
      cvnz_4      <= cvnz;
      b_4         <= b_3;
      dest_cfg_4  <= dest_cfg_3;
      wb_cfg_4    <= wb_cfg_3;
      addrc       <= dest_addr_3;
      pcn_4       <= pcn_3;
      cond_jump_4 <= cond_jump_3;
      jz_4        <= jz_3;
    end
  end

  // operand select, immediate zero extended
  always_comb
  begin
    case (src_cfg_2)
      SRC_RR:  {a_2, b_2} = {qra, qrb};
      SRC_RI:  {a_2, b_2} = {qra, data_t'(imm_2)};
      SRC_PR:  {a_2, b_2} = {pcn_2, qrb};
      SRC_PI:  {a_2, b_2} = {pcn_2, data_t'(imm_2)};
      default: {a_2, b_2} = '0;  // reserved
    endcase
  end

  always_comb
  begin
    case (wb_cfg_4)
      WB_Z:    wb_data = data_t'(cvnz_4[0]);
      WB_N:    wb_data = data_t'(cvnz_4[1]);
      WB_V:    wb_data = data_t'(cvnz_4[2]);
      WB_C:    wb_data = data_t'(cvnz_4[3]);
      default: wb_data = y_4;  // result
    endcase
  end

  always_comb
  begin
    wec    = 1'b0;
    spw_we = 1'b0;
    take   = 1'b0;
    if (vld_4)
    begin
      case (dest_cfg_4)
        DEST_REG:   wec = 1'b1;
        DEST_JUMP:  take = cond_jump_4 ? (b_4[0] ^ jz_4) : 1'b1;
        DEST_STORE: spw_we = 1'b1;
        default:    take = 1'b0;  // dest none
      endcase
    end
  end

  assign set_pc         = take & (wb_data != pcn_4);  // jump to next inst needs no flush
  assign flush_pipeline = set_pc;
  assign spw_addr       = b_4;
  assign spw_data       = wb_data;

endmodule

`default_nettype wire

//--- hw/sxp.sv
`default_nettype none

module sxp
(
  input  wire                 clk,
  input  wire                 reset_b,
  input  wire sxp_pkg::inst_t mem_inst,  // instruction memory read data
  output sxp_pkg::data_t      mem_pc,    // instruction memory address
  output logic                spw_we,    // scratch-pad write strobe
  output sxp_pkg::data_t      spw_addr,
  output sxp_pkg::data_t      spw_data
);

  import sxp_pkg::*;

  // stage 1
  logic      inst_vld;
  dest_cfg_e dest_cfg;
  src_cfg_e  src_cfg;
  alu_op_e   alu_op;
  wb_cfg_e   wb_cfg;
  rf_addr_t  dest_addr;
  rf_addr_t  addra;
  rf_addr_t  addrb;
  imm_t      imm;
  data_t     pcn;
  logic      cond_jump;
  logic      jz;
  logic      a_en;
  logic      b_en;
  logic      dest_en;
  logic      stall;
  // register file
  data_t     qra;
  data_t     qrb;
  logic      wec;
  rf_addr_t  addrc;
  data_t     wb_data;
  // alu
  alu_op_e   alu_op_3;
  data_t     a_3;
  data_t     b_3;
  data_t     y;
  cvnz_t     cvnz;
  // redirect
  logic      set_pc;
  logic      flush_pipeline;

  sxp_fetch i_fetch (
    .clk(clk), .reset_b(reset_b), .stall(stall), .set_pc(set_pc),
    .pc_init(wb_data), .mem_inst(mem_inst), .mem_pc(mem_pc), .pcn(pcn),
    .inst_vld(inst_vld), .dest_cfg(dest_cfg), .src_cfg(src_cfg), .alu_op(alu_op),
    .wb_cfg(wb_cfg), .dest_addr(dest_addr), .addra(addra), .addrb(addrb), .imm(imm),
    .cond_jump(cond_jump), .jz(jz), .a_en(a_en), .b_en(b_en), .dest_en(dest_en)
  );

  sxp_regf i_regf (
    .clk(clk), .reset_b(reset_b), .addra(addra), .addrb(addrb), .addrc(addrc),
    .a_en(a_en), .b_en(b_en), .wec(wec), .dc(wb_data), .qra(qra), .qrb(qrb)
  );

  sxp_regf_status i_regf_status (
    .clk(clk), .reset_b(reset_b), .dest_en(dest_en), .dest_addr(dest_addr),
    .addra(addra), .addrb(addrb), .addrc(addrc), .a_en(a_en), .b_en(b_en),
    .wec(wec), .flush_pipeline(flush_pipeline), .stall(stall)
  );

  sxp_alu i_alu (
    .op(alu_op_3), .a(a_3), .b(b_3), .y(y), .cvnz(cvnz)
  );

  sxp_execute i_execute (
    .clk(clk), .reset_b(reset_b), .stall(stall), .inst_vld(inst_vld),
    .dest_cfg(dest_cfg), .src_cfg(src_cfg), .alu_op(alu_op), .wb_cfg(wb_cfg),
    .dest_addr(dest_addr), .imm(imm), .pcn(pcn), .cond_jump(cond_jump), .jz(jz),
    .qra(qra), .qrb(qrb), .y(y), .cvnz(cvnz), .alu_op_3(alu_op_3), .a_3(a_3),
    .b_3(b_3), .wec(wec), .addrc(addrc), .wb_data(wb_data), .set_pc(set_pc),
    .flush_pipeline(flush_pipeline), .spw_we(spw_we), .spw_addr(spw_addr),
    .spw_data(spw_data)
  );

endmodule

`default_nettype wire

//--- verif/sxp_tb.sv
`default_nettype none

module sxp_tb;

  import sxp_pkg::*;

  logic  clk;
  logic  reset_b;
  inst_t mem_inst;
  data_t mem_pc;
  logic  spw_we;
  data_t spw_addr;
  data_t spw_data;

  inst_t rom [256];      // instruction memory, word addressed
  data_t rom_addr;       // address registered by the memory
  int    prog_len;       // next free rom word
  data_t exp_addr_q[$];  // expected stores, in program order
  data_t exp_data_q[$];
  int    seed = 32'h516f;
  int    errors;
  int    checks;
  int    tests;
  int    failed;

  sxp dut (
    .clk(clk), .reset_b(reset_b), .mem_inst(mem_inst), .mem_pc(mem_pc),
    .spw_we(spw_we), .spw_addr(spw_addr), .spw_data(spw_data)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // synchronous rom, data for the pc presented at the previous edge
  always @(posedge clk)
    rom_addr <= mem_pc;

  always @(negedge clk)
    mem_inst <= rom[rom_addr[7:0]];

  task automatic check_value(input string name, input data_t got, input data_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("MISMATCH %s got %h expected %h", name, got, exp);
    end
  endtask

  // store monitor, pops one expected store per strobe
  always @(negedge clk)
  begin
    if (reset_b && spw_we)
    begin
      if (exp_addr_q.size() == 0)
      begin
        errors++;
        $display("unexpected store to %h with data %h, none left in the model", spw_addr,
                 spw_data);
      end
      else
      begin
        check_value("spw_addr", spw_addr, exp_addr_q.pop_front());
        check_value("spw_data", spw_data, exp_data_q.pop_front());
      end
    end
  end

  // result in 31:0, flags {c, v, n, z} in 35:32
  function automatic logic [35:0] sxp_ref_alu(input logic [2:0] op, input data_t a,
                                              input data_t b);
    logic [32:0] wide;
    data_t       y;
    logic        c;
    logic        v;
    c = 1'b0;
    v = 1'b0;
    case (op)
      ALU_ADD:
      begin
        wide = {1'b0, a} + {1'b0, b};
        y    = wide[31:0];
        c    = wide[32];
        v    = (a[31] ~^ b[31]) & (a[31] ^ y[31]);  // equal signs in, other sign out
      end
      ALU_SUB:
      begin
        y = a - b;
        c = (a >= b);                             // no borrow
        v = (a[31] ^ b[31]) & (a[31] ^ y[31]);
      end
      ALU_AND: y = a & b;
      ALU_OR:  y = a | b;
      ALU_XOR: y = a ^ b;
      ALU_SHL: y = a << b[4:0];
      ALU_SHR: y = a >> b[4:0];
      default: y = b;
    endcase
    return {c, v, y[31], (y == 32'h0), y};
  endfunction

  function automatic data_t rand32();
    return $random(seed);
  endfunction

  function automatic inst_t encode_imm(input logic [1:0] dest, input logic [2:0] src,
                                       input logic [2:0] op, input logic [3:0] wb,
                                       input rf_addr_t rd, input imm_t imm);
    return {dest, src, op, wb, rd, imm};
  endfunction

  function automatic inst_t encode_reg(input logic [1:0] dest, input logic [2:0] src,
                                       input logic [2:0] op, input logic [3:0] wb,
                                       input rf_addr_t rd, input rf_addr_t ra,
                                       input rf_addr_t rb, input logic jz, input logic cj);
    return {dest, src, op, wb, rd, ra, rb, 6'b0, jz, cj};
  endfunction

  task automatic clear_rom();
    int i;
    for (i = 0; i < 256; i++)
      rom[i] = {2'b11, 22'h0, 8'(i)};  // dest none, harmless if fetched
    prog_len = 0;
  endtask

  task automatic emit(input inst_t inst);
    rom[prog_len] = inst;
    prog_len++;
  endtask

  // three dependent writes to one register
  task automatic load_const(input rf_addr_t rd, input data_t value);
    emit(encode_imm(DEST_REG, SRC_RI, ALU_PASSB, WB_RESULT, rd, value[31:16]));
    emit(encode_imm(DEST_REG, SRC_RI, ALU_SHL, WB_RESULT, rd, 16'd16));
    emit(encode_imm(DEST_REG, SRC_RI, ALU_OR, WB_RESULT, rd, value[15:0]));
  endtask

  // stores rd + tag at address tag
  task automatic store_tag(input rf_addr_t rd, input imm_t tag);
    emit(encode_imm(DEST_STORE, SRC_RI, ALU_ADD, WB_RESULT, rd, tag));
  endtask

  task automatic halt_loop();
    emit(encode_imm(DEST_JUMP, SRC_PI, ALU_SUB, WB_RESULT, 4'd0, 16'd1));  // pcn - 1
  endtask

  // in-order interpreter of the rom, fills the expected store queues
  task automatic run_model();
    data_t       regs [16];
    data_t       pc;
    data_t       a;
    data_t       b;
    data_t       wb;
    inst_t       inst;
    logic [35:0] r;
    logic        take;
    logic        done;
    int          steps;
    int          i;
    for (i = 0; i < 16; i++)
      regs[i] = '0;
    pc    = '0;
    done  = 1'b0;
    steps = 0;
    exp_addr_q.delete();
    exp_data_q.delete();
    while (!done && steps < 1000)
    begin
      inst = rom[pc[7:0]];
      steps++;
      case (inst[29:27])
        3'b000:  {a, b} = {regs[inst[15:12]], regs[inst[11:8]]};
        3'b001:  {a, b} = {regs[inst[19:16]], data_t'(inst[15:0])};
        3'b010:  {a, b} = {pc + 32'd1, regs[inst[11:8]]};
        3'b011:  {a, b} = {pc + 32'd1, data_t'(inst[15:0])};
        default: {a, b} = '0;
      endcase
      r = sxp_ref_alu(inst[26:24], a, b);
      case (inst[23:20])
        4'b0100: wb = data_t'(r[32]);
        4'b0101: wb = data_t'(r[33]);
        4'b0110: wb = data_t'(r[34]);
        4'b0111: wb = data_t'(r[35]);
        default: wb = r[31:0];
      endcase
      take = 1'b0;
      if (!inst[29])                                      // 1xx sources do nothing
      begin
        case (inst[31:30])
          2'b00: regs[inst[19:16]] = wb;
          2'b01: take = !(inst[0] && !inst[27]) || (b[0] ^ inst[1]);  // cond needs reg b
          2'b10:
          begin
            exp_addr_q.push_back(b);
            exp_data_q.push_back(wb);
          end
          default: take = 1'b0;
        endcase
      end
      if (take && wb == pc)
        done = 1'b1;                                      // jump to self ends the program
      else if (take)
        pc = wb;
      else
        pc = pc + 32'd1;
    end
    if (!done)
    begin
      errors++;
      $display("reference model never reached the final self jump");
    end
  endtask

  task automatic hold_reset();
    @(negedge clk);
    reset_b = 1'b0;
  endtask

  task automatic run_program(input string name);
    int err_start;
    int expected;
    int cyc;
    err_start = errors;
    run_model();
    expected = exp_addr_q.size();
    for (cyc = 0; cyc < 16; cyc++)
    begin
      @(negedge clk);
      check_value("spw_we", data_t'(spw_we), 32'h0);   // quiet during reset
    end
    reset_b = 1'b1;
    cyc = 0;
    while (exp_addr_q.size() != 0 && cyc < 4000)
    begin
      @(negedge clk);
      cyc++;
    end
    if (exp_addr_q.size() != 0)
    begin
      errors++;
      $display("timeout in %s, %0d of %0d stores never appeared", name, exp_addr_q.size(),
               expected);
    end
    for (cyc = 0; cyc < 40; cyc++)
      @(negedge clk);                                   // catch trailing extra stores
    tests++;
    if (errors != err_start)
      failed++;
    $display("%-18s %s  stores %0d  errors %0d", name, (errors == err_start) ? "pass" : "fail",
             expected, errors - err_start);
  endtask

  task automatic build_first_store();
    load_const(4'd1, 32'h1234_5678);
    load_const(4'd2, rand32());
    emit(encode_reg(DEST_REG, SRC_RR, ALU_ADD, WB_RESULT, 4'd3, 4'd1, 4'd2, 1'b0, 1'b0));
    store_tag(4'd3, 16'h0040);
    halt_loop();
  endtask

  task automatic build_alu_ops();
    int rnd;
    int op;
    for (rnd = 0; rnd < 2; rnd++)
    begin
      load_const(4'd1, rand32());
      load_const(4'd2, rand32());
      for (op = 0; op < 8; op++)
      begin
        emit(encode_reg(DEST_STORE, SRC_RR, 3'(op), WB_RESULT, 4'd0, 4'd1, 4'd2, 1'b0, 1'b0));
        emit(encode_imm(DEST_STORE, SRC_RI, 3'(op), WB_RESULT, 4'd1, imm_t'(rand32())));
      end
    end
    halt_loop();
  endtask

  task automatic build_dependent_chain();
    int k;
    load_const(4'd1, rand32());
    load_const(4'd4, rand32());
    for (k = 0; k < 4; k++)
    begin
      emit(encode_imm(DEST_REG, SRC_RI, ALU_ADD, WB_RESULT, 4'd4, imm_t'(rand32())));
      store_tag(4'd4, imm_t'(k + 1));                  // reads r4 right after its write
    end
    emit(encode_reg(DEST_REG, SRC_RR, ALU_SUB, WB_RESULT, 4'd5, 4'd4, 4'd1, 1'b0, 1'b0));
    emit(encode_reg(DEST_REG, SRC_RR, ALU_ADD, WB_RESULT, 4'd6, 4'd5, 4'd4, 1'b0, 1'b0));
    emit(encode_reg(DEST_STORE, SRC_RR, ALU_XOR, WB_RESULT, 4'd0, 4'd5, 4'd6, 1'b0, 1'b0));
    halt_loop();
  endtask

  task automatic build_flags();
    rf_addr_t ra_list [4] = '{4'd1, 4'd1, 4'd7, 4'd2};
    rf_addr_t rb_list [4] = '{4'd2, 4'd3, 4'd8, 4'd1};
    data_t    v;
    int       p;
    int       w;
    int       op;
    v = rand32();
    load_const(4'd1, v);
    load_const(4'd2, rand32());
    load_const(4'd3, v);                               // equal operands give z and c
    load_const(4'd7, 32'h7fff_ffff);
    load_const(4'd8, 32'h0000_0001);                   // add overflows into the sign
    for (p = 0; p < 4; p++)
      for (w = 4; w < 8; w++)
        for (op = 0; op < 2; op++)                     // add then sub
          emit(encode_reg(DEST_STORE, SRC_RR, 3'(op), 4'(w), 4'd0, ra_list[p], rb_list[p],
                          1'b0, 1'b0));
    emit(encode_reg(DEST_REG, SRC_RR, ALU_SUB, WB_C, 4'd9, 4'd1, 4'd2, 1'b0, 1'b0));
    store_tag(4'd9, 16'h00f0);
    halt_loop();
  endtask

  task automatic build_uncond_jump();
    load_const(4'd1, rand32());
    store_tag(4'd1, 16'h0001);
    emit(encode_imm(DEST_JUMP, SRC_PI, ALU_ADD, WB_RESULT, 4'd0, 16'd3));  // over three
    store_tag(4'd1, 16'h00e1);
    emit(encode_imm(DEST_REG, SRC_RI, ALU_ADD, WB_RESULT, 4'd1, 16'h0100));
    store_tag(4'd1, 16'h00e2);
    store_tag(4'd1, 16'h0002);
    emit(encode_imm(DEST_JUMP, SRC_PI, ALU_ADD, WB_RESULT, 4'd0, 16'd0));  // to next, no flush
    store_tag(4'd1, 16'h0003);
    emit(encode_imm(DEST_JUMP, SRC_PI, ALU_PASSB, WB_RESULT, 4'd0, imm_t'(prog_len + 3)));
    store_tag(4'd1, 16'h00e3);
    store_tag(4'd1, 16'h00e4);
    store_tag(4'd1, 16'h0004);
    halt_loop();
  endtask

  task automatic build_cond_jump();
    int jz;
    int rb;
    int j;
    load_const(4'd1, rand32());
    emit(encode_imm(DEST_REG, SRC_RI, ALU_PASSB, WB_RESULT, 4'd2, 16'd2));
    emit(encode_imm(DEST_REG, SRC_RI, ALU_PASSB, WB_RESULT, 4'd3, 16'd3));
    for (jz = 0; jz < 2; jz++)
      for (rb = 2; rb < 4; rb++)
      begin
        // target is pcn + rb, bit 0 of rb decides
        emit(encode_reg(DEST_JUMP, SRC_PR, ALU_ADD, WB_RESULT, 4'd0, 4'd0, 4'(rb), 1'(jz),
                        1'b1));
        for (j = 0; j < 3; j++)
          store_tag(4'd1, imm_t'(16'h0100 * (jz * 2 + rb - 1) + j));
      end
    halt_loop();
  endtask

  initial
  begin
    reset_b  = 1'b0;
    mem_inst = '0;
    errors   = 0;
    checks   = 0;
    tests    = 0;
    failed   = 0;
    clear_rom();

    hold_reset();
    clear_rom();
    build_first_store();
    run_program("first_store");

    hold_reset();
    clear_rom();
    build_alu_ops();
    run_program("alu_ops");

    hold_reset();
    clear_rom();
    build_dependent_chain();
    run_program("dependent_chain");

    hold_reset();
    clear_rom();
    build_flags();
    run_program("flag_writeback");

    hold_reset();
    clear_rom();
    build_uncond_jump();
    run_program("uncond_jump");

    hold_reset();
    clear_rom();
    build_cond_jump();
    run_program("cond_jump");

    $display("tests %0d  failed %0d  checks %0d  errors %0d", tests, failed, checks, errors);
    if (errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- sxp.f
+incdir+hw
hw/sxp_pkg.sv
hw/sxp_alu.sv
hw/sxp_regf.sv
hw/sxp_regf_status.sv
hw/sxp_fetch.sv
hw/sxp_execute.sv
hw/sxp.sv
verif/sxp_tb.sv
